// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tlb_top_tb -o Vtlb_top_tb

# The simulation status is judged from the log
./obj_dir/Vtlb_top_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// ==== src/tlb_cmd_pkg.sv ====
`default_nettype none

package tlb_cmd_pkg;

    typedef enum logic [1:0] {
        CMD_WRITE      = 2'd0,
        CMD_SEARCH     = 2'd1,
        CMD_INVALIDATE = 2'd2
    } cmd_op_e;

    // INVTLB op field
    typedef enum logic [2:0] {
        INV_ALL       = 3'd0,
        INV_ALL_ALT   = 3'd1,
        INV_GLOBAL    = 3'd2,
        INV_NONGLOBAL = 3'd3,
        INV_ASID      = 3'd4,
        INV_ASID_VA   = 3'd5,
        INV_OTHER_VA  = 3'd6
    } inv_op_e;

    typedef enum logic {
        MG_IDLE = 1'b0,
        MG_RESP = 1'b1
    } mgmt_state_e;

endpackage

`default_nettype wire

// ==== src/tlb_defines.svh ====
`ifndef TLB_DEFINES_SVH
`define TLB_DEFINES_SVH

// TLB geometry
`define TLB_NUM     16
`define TLB_IDX_W   4

// Address and field widths
`define TLB_VA_W    32
`define TLB_VPPN_W  19
`define TLB_PPN_W   20
`define TLB_ASID_W  10

// Page-size codes as held in the PS field
`define TLB_PS_4K   12
`define TLB_PS_2M   21

`endif

// ==== src/tlb_entry_array.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_entry_array
    import tlb_entry_pkg::*;
    import tlb_cmd_pkg::*;
(
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         wr_en,
    input  tlb_idx_t                     wr_index,
    input  tlb_cpr_t                     wr_cpr,
    input  tlb_trans_t                   wr_trans0,
    input  tlb_trans_t                   wr_trans1,
    input  logic                         inv_en,
    input  inv_op_e                      inv_op,
    input  asid_t                        inv_asid,
    input  vppn_t                        inv_vppn,
    output logic [`TLB_NUM*CPR_W-1:0]    cpr_flat,
    output logic [`TLB_NUM*TRANS_W-1:0]  trans0_flat,
    output logic [`TLB_NUM*TRANS_W-1:0]  trans1_flat
);

    // E bits live apart so that only they need a reset
    tlb_vec_t         e_q;
    logic [CPR_E-1:0] cpr_q    [`TLB_NUM];
    tlb_trans_t       trans0_q [`TLB_NUM];
    tlb_trans_t       trans1_q [`TLB_NUM];

    tlb_vec_t ent_g;
    tlb_vec_t asid_eq;
    tlb_vec_t vppn_eq;
    tlb_vec_t inv_sel;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            cpr_q[wr_index]    <= wr_cpr[CPR_E-1:0];
            trans0_q[wr_index] <= wr_trans0;
            trans1_q[wr_index] <= wr_trans1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            e_q <= '0;
        end else if (wr_en) begin
            e_q[wr_index] <= wr_cpr[CPR_E];
        end else if (inv_en) begin
            e_q <= e_q & ~inv_sel;
        end
    end

    for (genvar i = 0; i < `TLB_NUM; i++) begin : g_entry
        logic  is_4k;
        vppn_t vppn;

        assign vppn  = cpr_q[i][CPR_VPPN_LSB +: `TLB_VPPN_W];
        assign is_4k = cpr_q[i][CPR_PS_LSB +: PS_W] == PS_W'(`TLB_PS_4K);

        assign ent_g[i]   = cpr_q[i][CPR_G];
        assign asid_eq[i] = cpr_q[i][CPR_ASID_LSB +: `TLB_ASID_W] == inv_asid;
        // A 2M entry covers a whole group of page pairs
        assign vppn_eq[i] = (vppn[`TLB_VPPN_W-1:HUGE_VPPN_LSB]
                                == inv_vppn[`TLB_VPPN_W-1:HUGE_VPPN_LSB])
                            && (!is_4k || vppn[HUGE_VPPN_LSB-1:0]
                                == inv_vppn[HUGE_VPPN_LSB-1:0]);

        assign cpr_flat[i*CPR_W +: CPR_W]        = {e_q[i], cpr_q[i]};
        assign trans0_flat[i*TRANS_W +: TRANS_W] = trans0_q[i];
        assign trans1_flat[i*TRANS_W +: TRANS_W] = trans1_q[i];
    end

    always_comb begin
        case (inv_op)
            INV_ALL, INV_ALL_ALT: inv_sel = '1;
            INV_GLOBAL:           inv_sel = ent_g;
            INV_NONGLOBAL:        inv_sel = ~ent_g;
            INV_ASID:             inv_sel = ~ent_g & asid_eq;
            INV_ASID_VA:          inv_sel = ~ent_g & asid_eq & vppn_eq;
            INV_OTHER_VA:         inv_sel = (ent_g | ~asid_eq) & vppn_eq;
            default:              inv_sel = '0;
        endcase
    end

    // Management issues one command at a time
    wr_inv_excl: assert property (@(posedge clk) disable iff (!rstn) !(wr_en && inv_en))
        else $error("write and invalidate strobes together");

endmodule

`default_nettype wire

// ==== src/tlb_entry_pkg.sv ====
`default_nettype none

`include "tlb_defines.svh"

package tlb_entry_pkg;

    typedef logic [`TLB_VA_W-1:0]   vaddr_t;
    typedef logic [`TLB_VA_W-1:0]   paddr_t;
    typedef logic [`TLB_VPPN_W-1:0] vppn_t;
    typedef logic [`TLB_PPN_W-1:0]  ppn_t;
    typedef logic [`TLB_ASID_W-1:0] asid_t;
    typedef logic [`TLB_IDX_W-1:0]  tlb_idx_t;
    typedef logic [`TLB_NUM-1:0]    tlb_vec_t;

    localparam int PS_W    = 6;
    localparam int CPR_W   = 1 + `TLB_ASID_W + 1 + PS_W + `TLB_VPPN_W;
    localparam int TRANS_W = 1 + 1 + 2 + 2 + `TLB_PPN_W;

    // Compare word, E ASID G PS VPPN from the top
    localparam int CPR_VPPN_LSB = 0;
    localparam int CPR_PS_LSB   = CPR_VPPN_LSB + `TLB_VPPN_W;
    localparam int CPR_G        = CPR_PS_LSB + PS_W;
    localparam int CPR_ASID_LSB = CPR_G + 1;
    localparam int CPR_E        = CPR_ASID_LSB + `TLB_ASID_W;

    // Translate word, V D MAT PLV PPN from the top
    localparam int TR_PPN_LSB = 0;
    localparam int TR_PLV_LSB = TR_PPN_LSB + `TLB_PPN_W;
    localparam int TR_MAT_LSB = TR_PLV_LSB + 2;
    localparam int TR_D       = TR_MAT_LSB + 2;
    localparam int TR_V       = TR_D + 1;

    typedef logic [CPR_W-1:0]     tlb_cpr_t;
    typedef logic [TRANS_W-1:0]   tlb_trans_t;
    typedef logic [`TLB_VA_W-1:0] dmw_t;

    // DMW CSR layout
    localparam int DMW_VSEG_LSB = 29;
    localparam int DMW_PSEG_LSB = 25;
    localparam int DMW_SEG_W    = `TLB_VA_W - DMW_VSEG_LSB;
    localparam int DMW_CACHED   = 4;

    // Low VPPN bits that a 2M entry ignores
    localparam int HUGE_VPPN_LSB = `TLB_PS_2M - `TLB_PS_4K;

endpackage

`default_nettype wire

// ==== src/tlb_match.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_match
    import tlb_entry_pkg::*;
(
    input  logic [`TLB_NUM*CPR_W-1:0] cpr_flat,
    input  asid_t                     asid,
    input  vaddr_t                    va,
    output tlb_vec_t                  hit,
    output tlb_vec_t                  odd
);

    for (genvar i = 0; i < `TLB_NUM; i++) begin : g_cmp
        tlb_cpr_t cpr;
        vppn_t    vppn;
        logic     is_4k;
        logic     asid_ok;
        logic     hi_eq;
        logic     lo_eq;

        assign cpr     = cpr_flat[i*CPR_W +: CPR_W];
        assign vppn    = cpr[CPR_VPPN_LSB +: `TLB_VPPN_W];
        assign is_4k   = cpr[CPR_PS_LSB +: PS_W] == PS_W'(`TLB_PS_4K);
        assign asid_ok = cpr[CPR_G] || (cpr[CPR_ASID_LSB +: `TLB_ASID_W] == asid);

        // VA bits 31..22 against the top of the VPPN
        assign hi_eq = vppn[`TLB_VPPN_W-1:HUGE_VPPN_LSB] == va[`TLB_VA_W-1:`TLB_PS_2M+1];
        assign lo_eq = vppn[HUGE_VPPN_LSB-1:0] == va[`TLB_PS_2M:`TLB_PS_4K+1];

        assign hit[i] = cpr[CPR_E] && asid_ok && hi_eq && (lo_eq || !is_4k);
        assign odd[i] = is_4k ? va[`TLB_PS_4K] : va[`TLB_PS_2M];
    end

    // Overlapping entries would make the translation ambiguous
    always_comb begin
        if (!$isunknown(hit)) begin
            hit_onehot: assert final ($onehot0(hit))
                else $error("multiple TLB entries hit");
        end
    end

endmodule

`default_nettype wire

// ==== src/tlb_mgmt.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_mgmt
    import tlb_entry_pkg::*;
    import tlb_cmd_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     cmd_valid,
    input  cmd_op_e  cmd_op,
    input  tlb_vec_t srch_hit,
    output logic     wr_en,
    output logic     inv_en,
    output logic     cmd_ready,
    output logic     rsp_hit,
    output tlb_idx_t rsp_index
);

    mgmt_state_e state;
    logic        accept;
    tlb_idx_t    srch_index;

    assign accept    = (state == MG_IDLE) && cmd_valid;
    assign wr_en     = accept && (cmd_op == CMD_WRITE);
    assign inv_en    = accept && (cmd_op == CMD_INVALIDATE);
    assign cmd_ready = state == MG_RESP;

    // Hit vector to index
    always_comb begin
        srch_index = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (srch_hit[i]) begin
                srch_index = tlb_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= MG_IDLE;
            rsp_hit   <= 1'b0;
            rsp_index <= '0;
        end else begin
            case (state)
                MG_IDLE: begin
                    if (cmd_valid) begin
                        state     <= MG_RESP;
                        rsp_hit   <= (cmd_op == CMD_SEARCH) && (|srch_hit);
                        rsp_index <= srch_index;
                    end
                end
                default: begin
                    state <= MG_IDLE;
                end
            endcase
        end
    end

    // Requester holds the opcode until it sees ready
    op_stable: assert property (@(posedge clk) disable iff (!rstn)
        cmd_valid && !cmd_ready |=> $stable(cmd_op))
        else $error("cmd_op changed before cmd_ready");

endmodule

`default_nettype wire

// ==== src/tlb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_top
    import tlb_entry_pkg::*;
    import tlb_cmd_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       flush,
    input  logic       cmd_valid,
    input  cmd_op_e    cmd_op,
    input  tlb_idx_t   cmd_index,
    input  tlb_cpr_t   cmd_cpr,
    input  tlb_trans_t cmd_trans0,
    input  tlb_trans_t cmd_trans1,
    input  inv_op_e    cmd_inv_op,
    input  asid_t      cmd_asid,
    input  vaddr_t     cmd_va,
    output logic       cmd_ready,
    output logic       rsp_hit,
    output tlb_idx_t   rsp_index,
    input  logic       xl_req,
    input  vaddr_t     xl_va,
    input  logic       xl_stall,
    input  asid_t      csr_asid,
    input  logic       pg,
    input  logic       da_cached,
    input  dmw_t       dmw0,
    input  dmw_t       dmw1,
    output logic       xl_valid,
    output logic       xl_tlb_hit,
    output logic       xl_page_valid,
    output logic       xl_dirty,
    output logic       xl_cached,
    output logic [1:0] xl_plv,
    output paddr_t     xl_pa
);

    logic [`TLB_NUM*CPR_W-1:0]   cpr_flat;
    logic [`TLB_NUM*TRANS_W-1:0] trans0_flat;
    logic [`TLB_NUM*TRANS_W-1:0] trans1_flat;
    tlb_vec_t                    xl_hit;
    tlb_vec_t                    xl_odd;
    tlb_vec_t                    srch_hit;
    logic                        wr_en;
    logic                        inv_en;

    tlb_entry_array entry_array_i (
        .clk         (clk),
        .rstn        (rstn),
        .wr_en       (wr_en),
        .wr_index    (cmd_index),
        .wr_cpr      (cmd_cpr),
        .wr_trans0   (cmd_trans0),
        .wr_trans1   (cmd_trans1),
        .inv_en      (inv_en),
        .inv_op      (cmd_inv_op),
        .inv_asid    (cmd_asid),
        .inv_vppn    (cmd_va[`TLB_VA_W-1:`TLB_PS_4K+1]),
        .cpr_flat    (cpr_flat),
        .trans0_flat (trans0_flat),
        .trans1_flat (trans1_flat)
    );

    tlb_match xl_match_i (
        .cpr_flat (cpr_flat),
        .asid     (csr_asid),
        .va       (xl_va),
        .hit      (xl_hit),
        .odd      (xl_odd)
    );

    // TLBSRCH needs no even/odd select
    tlb_match srch_match_i (
        .cpr_flat (cpr_flat),
        .asid     (cmd_asid),
        .va       (cmd_va),
        .hit      (srch_hit),
        .odd      ()
    );

    tlb_translate_pipe translate_pipe_i (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .xl_req        (xl_req),
        .xl_va         (xl_va),
        .xl_stall      (xl_stall),
        .hit           (xl_hit),
        .odd           (xl_odd),
        .cpr_flat      (cpr_flat),
        .trans0_flat   (trans0_flat),
        .trans1_flat   (trans1_flat),
        .pg            (pg),
        .da_cached     (da_cached),
        .dmw0          (dmw0),
        .dmw1          (dmw1),
        .xl_valid      (xl_valid),
        .xl_tlb_hit    (xl_tlb_hit),
        .xl_page_valid (xl_page_valid),
        .xl_dirty      (xl_dirty),
        .xl_cached     (xl_cached),
        .xl_plv        (xl_plv),
        .xl_pa         (xl_pa)
    );

    tlb_mgmt mgmt_i (
        .clk       (clk),
        .rstn      (rstn),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .srch_hit  (srch_hit),
        .wr_en     (wr_en),
        .inv_en    (inv_en),
        .cmd_ready (cmd_ready),
        .rsp_hit   (rsp_hit),
        .rsp_index (rsp_index)
    );

endmodule

`default_nettype wire

// ==== src/tlb_translate_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_translate_pipe
    import tlb_entry_pkg::*;
(
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         flush,
    input  logic                         xl_req,
    input  vaddr_t                       xl_va,
    input  logic                         xl_stall,
    input  tlb_vec_t                     hit,
    input  tlb_vec_t                     odd,
    input  logic [`TLB_NUM*CPR_W-1:0]    cpr_flat,
    input  logic [`TLB_NUM*TRANS_W-1:0]  trans0_flat,
    input  logic [`TLB_NUM*TRANS_W-1:0]  trans1_flat,
    input  logic                         pg,
    input  logic                         da_cached,
    input  dmw_t                         dmw0,
    input  dmw_t                         dmw1,
    output logic                         xl_valid,
    output logic                         xl_tlb_hit,
    output logic                         xl_page_valid,
    output logic                         xl_dirty,
    output logic                         xl_cached,
    output logic [1:0]                   xl_plv,
    output paddr_t                       xl_pa
);

    logic       s1_valid;
    vaddr_t     s1_va;
    tlb_vec_t   s1_hit;
    tlb_vec_t   s1_odd;

    tlb_trans_t sel_trans;
    logic       sel_4k;
    logic       tlb_hit;
    ppn_t       ppn;
    paddr_t     tlb_pa;
    logic       dmw0_hit;
    logic       dmw1_hit;
    logic       use_tlb;
    paddr_t     pa_d;
    logic       cached_d;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            xl_valid <= 1'b0;
        end else if (flush) begin
            s1_valid <= 1'b0;
            xl_valid <= 1'b0;
        end else if (!xl_stall) begin
            s1_valid <= xl_req;
            xl_valid <= s1_valid;
        end
    end

    // Stage 1
    always_ff @(posedge clk) begin
        if (!xl_stall) begin
            s1_va  <= xl_va;
            s1_hit <= hit;
            s1_odd <= odd;
        end
    end

    // Hit is one-hot, so OR-ing the selected words picks the entry
    always_comb begin
        sel_trans = '0;
        sel_4k    = 1'b0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (s1_hit[i]) begin
                sel_trans = sel_trans | (s1_odd[i] ? trans1_flat[i*TRANS_W +: TRANS_W]
                                                   : trans0_flat[i*TRANS_W +: TRANS_W]);
                sel_4k    = sel_4k
                            | (cpr_flat[i*CPR_W + CPR_PS_LSB +: PS_W] == PS_W'(`TLB_PS_4K));
            end
        end
    end

    assign tlb_hit = |s1_hit;
    assign ppn     = sel_trans[TR_PPN_LSB +: `TLB_PPN_W];
    assign tlb_pa  = sel_4k ? {ppn, s1_va[`TLB_PS_4K-1:0]}
                            : {ppn[`TLB_PPN_W-1:`TLB_PS_2M-`TLB_PS_4K], s1_va[`TLB_PS_2M-1:0]};

    assign dmw0_hit = s1_va[`TLB_VA_W-1:DMW_VSEG_LSB] == dmw0[`TLB_VA_W-1:DMW_VSEG_LSB];
    assign dmw1_hit = s1_va[`TLB_VA_W-1:DMW_VSEG_LSB] == dmw1[`TLB_VA_W-1:DMW_VSEG_LSB];

    always_comb begin
        use_tlb = 1'b0;
        if (!pg) begin
            pa_d     = s1_va;
            cached_d = da_cached;
        end else if (dmw0_hit) begin
            pa_d     = {dmw0[DMW_PSEG_LSB +: DMW_SEG_W], s1_va[DMW_VSEG_LSB-1:0]};
            cached_d = dmw0[DMW_CACHED];
        end else if (dmw1_hit) begin
            pa_d     = {dmw1[DMW_PSEG_LSB +: DMW_SEG_W], s1_va[DMW_VSEG_LSB-1:0]};
            cached_d = dmw1[DMW_CACHED];
        end else begin
            use_tlb  = 1'b1;
            pa_d     = tlb_hit ? tlb_pa : '0;
            cached_d = tlb_hit && (sel_trans[TR_MAT_LSB +: 2] == 2'd1);
        end
    end

    // Stage 2, page flags only for a mapped TLB access
    always_ff @(posedge clk) begin
        if (!xl_stall) begin
            xl_pa         <= pa_d;
            xl_cached     <= cached_d;
            xl_tlb_hit    <= use_tlb && tlb_hit;
            xl_page_valid <= use_tlb && sel_trans[TR_V];
            xl_dirty      <= use_tlb && sel_trans[TR_D];
            xl_plv        <= use_tlb ? sel_trans[TR_PLV_LSB +: 2] : 2'b00;
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_NS      = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    // Release reset just after an edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/tlb_top_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_top_tb
    import tlb_entry_pkg::*;
    import tlb_cmd_pkg::*;
();

    // About 700 cycles of tests plus margin
    localparam int CYCLE_LIMIT = 2000;

    typedef struct packed {
        logic       tlb_hit;
        logic       page_valid;
        logic       dirty;
        logic       cached;
        logic [1:0] plv;
        paddr_t     pa;
        int         due;
    } exp_xl_t;

    typedef struct packed {
        logic     hit;
        tlb_idx_t idx;
    } srch_res_t;

    logic       clk;
    logic       rstn;
    logic       flush;
    logic       cmd_valid;
    cmd_op_e    cmd_op;
    tlb_idx_t   cmd_index;
    tlb_cpr_t   cmd_cpr;
    tlb_trans_t cmd_trans0;
    tlb_trans_t cmd_trans1;
    inv_op_e    cmd_inv_op;
    asid_t      cmd_asid;
    vaddr_t     cmd_va;
    logic       cmd_ready;
    logic       rsp_hit;
    tlb_idx_t   rsp_index;
    logic       xl_req;
    vaddr_t     xl_va;
    logic       xl_stall;
    asid_t      csr_asid;
    logic       pg;
    logic       da_cached;
    dmw_t       dmw0;
    dmw_t       dmw1;
    logic       xl_valid;
    logic       xl_tlb_hit;
    logic       xl_page_valid;
    logic       xl_dirty;
    logic       xl_cached;
    logic [1:0] xl_plv;
    paddr_t     xl_pa;

    // Reference copy of the entry array
    logic       m_e    [`TLB_NUM];
    asid_t      m_asid [`TLB_NUM];
    logic       m_g    [`TLB_NUM];
    logic       m_huge [`TLB_NUM];
    vppn_t      m_vppn [`TLB_NUM];
    tlb_trans_t m_t0   [`TLB_NUM];
    tlb_trans_t m_t1   [`TLB_NUM];

    exp_xl_t    exp_q[$];
    int         cycles;
    logic       check_en;
    integer     seed;

    tb_clock_gen #(.HALF_NS(4), .RESET_CYCLES(5)) clock_gen_i (
        .clk  (clk),
        .rstn (rstn)
    );

    tlb_top dut_i (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_index     (cmd_index),
        .cmd_cpr       (cmd_cpr),
        .cmd_trans0    (cmd_trans0),
        .cmd_trans1    (cmd_trans1),
        .cmd_inv_op    (cmd_inv_op),
        .cmd_asid      (cmd_asid),
        .cmd_va        (cmd_va),
        .cmd_ready     (cmd_ready),
        .rsp_hit       (rsp_hit),
        .rsp_index     (rsp_index),
        .xl_req        (xl_req),
        .xl_va         (xl_va),
        .xl_stall      (xl_stall),
        .csr_asid      (csr_asid),
        .pg            (pg),
        .da_cached     (da_cached),
        .dmw0          (dmw0),
        .dmw1          (dmw1),
        .xl_valid      (xl_valid),
        .xl_tlb_hit    (xl_tlb_hit),
        .xl_page_valid (xl_page_valid),
        .xl_dirty      (xl_dirty),
        .xl_cached     (xl_cached),
        .xl_plv        (xl_plv),
        .xl_pa         (xl_pa)
    );

    task automatic abort_run(input string what);
        $display("%0t: %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_pa(input string name, input paddr_t exp, input paddr_t act);
        if (exp !== act) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_index(input string name, input tlb_idx_t exp, input tlb_idx_t act);
        if (exp !== act) begin
            $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // 4K entries match the whole VPPN and 2M entries only VA bits 31..22
    function automatic logic vppn_match(input int i, input vppn_t v);
        if (m_huge[i]) begin
            return m_vppn[i][18:9] == v[18:9];
        end
        return m_vppn[i] == v;
    endfunction

    function automatic logic model_hit(input int i, input asid_t asid, input vaddr_t va);
        return m_e[i] && (m_g[i] || m_asid[i] == asid) && vppn_match(i, va[31:13]);
    endfunction

    function automatic exp_xl_t ref_translate(input vaddr_t va, input asid_t asid);
        exp_xl_t    r;
        tlb_trans_t t;
        logic       odd;
        r = '0;
        if (!pg) begin
            r.pa     = va;
            r.cached = da_cached;
        end else if (va[31:29] == dmw0[31:29]) begin
            r.pa     = {dmw0[27:25], va[28:0]};
            r.cached = dmw0[4];
        end else if (va[31:29] == dmw1[31:29]) begin
            r.pa     = {dmw1[27:25], va[28:0]};
            r.cached = dmw1[4];
        end else begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                if (model_hit(i, asid, va)) begin
                    odd          = m_huge[i] ? va[21] : va[12];
                    t            = odd ? m_t1[i] : m_t0[i];
                    r.tlb_hit    = 1'b1;
                    r.page_valid = t[25];
                    r.dirty      = t[24];
                    r.cached     = t[23:22] == 2'd1;
                    r.plv        = t[21:20];
                    r.pa         = m_huge[i] ? {t[19:9], va[20:0]} : {t[19:0], va[11:0]};
                end
            end
        end
        return r;
    endfunction

    function automatic srch_res_t ref_search(input asid_t asid, input vaddr_t va);
        srch_res_t r;
        r = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (model_hit(i, asid, va)) begin
                r.hit = 1'b1;
                r.idx = tlb_idx_t'(i);
            end
        end
        return r;
    endfunction

    // An address inside the even or odd half of entry i
    function automatic vaddr_t entry_va(input int i, input logic odd, input int lo);
        if (m_huge[i]) begin
            return {m_vppn[i][18:9], odd, lo[20:0]};
        end
        return {m_vppn[i], odd, lo[11:0]};
    endfunction

    // Ready comes exactly one cycle after acceptance
    task automatic run_cmd(input cmd_op_e op);
        cmd_op    = op;
        cmd_valid = 1'b1;
        @(negedge clk);
        check_flag("cmd_ready", 1'b0, cmd_ready);
        @(negedge clk);
        check_flag("cmd_ready", 1'b1, cmd_ready);
        @(posedge clk);
        #1 cmd_valid = 1'b0;
    endtask

    task automatic write_entry(input int i, input logic huge);
        int    r;
        vppn_t vppn;
        asid_t asid;
        logic  g;
        r    = $random(seed);
        // Index in VA bits 25..22 keeps entries apart and bit 31 low avoids the windows
        vppn = {1'b0, r[4:0], i[3:0], r[13:5]};
        asid = r[14] ? csr_asid : csr_asid ^ 10'h1;
        g    = r[16:15] == 2'b00;
        cmd_index  = tlb_idx_t'(i);
        cmd_cpr    = {1'b1, asid, g, huge ? 6'd21 : 6'd12, vppn};
        cmd_trans0 = tlb_trans_t'($random(seed));
        cmd_trans1 = tlb_trans_t'($random(seed));
        run_cmd(CMD_WRITE);
        m_e[i]    = 1'b1;
        m_asid[i] = asid;
        m_g[i]    = g;
        m_huge[i] = huge;
        m_vppn[i] = vppn;
        m_t0[i]   = cmd_trans0;
        m_t1[i]   = cmd_trans1;
    endtask

    task automatic fill_all();
        int r;
        for (int i = 0; i < `TLB_NUM; i++) begin
            r = $random(seed);
            write_entry(i, r[0]);
        end
    endtask

    task automatic search_check(input asid_t asid, input vaddr_t va);
        srch_res_t exp;
        cmd_asid = asid;
        cmd_va   = va;
        exp      = ref_search(asid, va);
        run_cmd(CMD_SEARCH);
        check_flag("rsp_hit", exp.hit, rsp_hit);
        if (exp.hit) begin
            check_index("rsp_index", exp.idx, rsp_index);
        end
    endtask

    task automatic invalidate(input int op, input asid_t asid, input vaddr_t va);
        logic sel;
        logic aeq;
        logic veq;
        cmd_inv_op = inv_op_e'(op[2:0]);
        cmd_asid   = asid;
        cmd_va     = va;
        run_cmd(CMD_INVALIDATE);
        for (int i = 0; i < `TLB_NUM; i++) begin
            aeq = m_asid[i] == asid;
            veq = vppn_match(i, va[31:13]);
            case (op)
                2:       sel = m_g[i];
                3:       sel = !m_g[i];
                4:       sel = !m_g[i] && aeq;
                5:       sel = !m_g[i] && aeq && veq;
                6:       sel = (m_g[i] || !aeq) && veq;
                default: sel = 1'b1;
            endcase
            if (sel) begin
                m_e[i] = 1'b0;
            end
        end
    endtask

    task automatic issue_xl(input vaddr_t va);
        exp_xl_t e;
        e      = ref_translate(va, csr_asid);
        e.due  = cycles + 2;
        xl_req = 1'b1;
        xl_va  = va;
        exp_q.push_back(e);
        @(posedge clk);
        #1 xl_req = 1'b0;
    endtask

    task automatic drain_xl();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run("timeout, the tests did not finish within the cycle limit");
        end
    end

    always @(negedge clk) begin : compare_xl
        exp_xl_t e;
        if (rstn && check_en) begin
            if (exp_q.size() != 0 && exp_q[0].due < cycles) begin
                abort_run("translation result did not arrive two cycles after request");
            end else if (xl_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("xl_valid high with no translation in flight");
                end else begin
                    e = exp_q.pop_front();
                    if (e.due != cycles) begin
                        abort_run("translation result arrived at the wrong cycle");
                    end else begin
                        check_flag("xl_tlb_hit", e.tlb_hit, xl_tlb_hit);
                        check_flag("xl_page_valid", e.page_valid, xl_page_valid);
                        check_flag("xl_dirty", e.dirty, xl_dirty);
                        check_flag("xl_cached", e.cached, xl_cached);
                        check_flag("xl_plv[1]", e.plv[1], xl_plv[1]);
                        check_flag("xl_plv[0]", e.plv[0], xl_plv[0]);
                        check_pa("xl_pa", e.pa, xl_pa);
                    end
                end
            end
        end
    end

    initial begin
        exp_xl_t a;
        int      r;
        seed       = 32'h9dfa0728;
        cycles     = 0;
        check_en   = 1'b1;
        flush      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = CMD_WRITE;
        cmd_index  = '0;
        cmd_cpr    = '0;
        cmd_trans0 = '0;
        cmd_trans1 = '0;
        cmd_inv_op = INV_ALL;
        cmd_asid   = '0;
        cmd_va     = '0;
        xl_req     = 1'b0;
        xl_va      = '0;
        xl_stall   = 1'b0;
        csr_asid   = 10'h2a6;
        pg         = 1'b1;
        da_cached  = 1'b0;
        dmw0       = 32'h8200_0010;
        dmw1       = 32'ha400_0000;
        for (int i = 0; i < `TLB_NUM; i++) begin
            m_e[i] = 1'b0;
        end

        @(posedge rstn);
        @(negedge clk);
        check_flag("cmd_ready", 1'b0, cmd_ready);
        check_flag("rsp_hit", 1'b0, rsp_hit);
        check_flag("xl_valid", 1'b0, xl_valid);
        @(posedge clk);
        #1;
        issue_xl(32'h1234_5678);
        drain_xl();

        // Random entries and then back-to-back translations of both halves
        fill_all();
        for (int i = 0; i < `TLB_NUM; i++) begin
            issue_xl(entry_va(i, 1'b0, $random(seed)));
            issue_xl(entry_va(i, 1'b1, $random(seed)));
        end
        drain_xl();

        // Both windows, window priority and direct address mode
        issue_xl(32'h8765_4321);
        issue_xl(32'ha0f0_0f0f);
        drain_xl();
        dmw1 = 32'h8a00_0000;
        issue_xl(32'h9abc_def0);
        drain_xl();
        pg = 1'b0;
        for (int k = 0; k < 4; k++) begin
            da_cached = k[0];
            issue_xl($random(seed));
            drain_xl();
        end
        pg = 1'b1;

        // Searches that hit and miss
        for (int i = 0; i < `TLB_NUM; i++) begin
            search_check(m_asid[i], entry_va(i, i[0], $random(seed)));
            search_check(m_asid[i] ^ 10'h3c0, entry_va(i, 1'b0, $random(seed)));
        end
        search_check(csr_asid, 32'h7fff_f000);

        // Stall in stage 1 and then in stage 2
        check_en = 1'b0;
        a        = ref_translate(entry_va(3, 1'b1, 0), csr_asid);
        xl_req   = 1'b1;
        xl_va    = entry_va(3, 1'b1, 0);
        @(posedge clk);
        #1 xl_req = 1'b0;
        // A window address waits at the input while the stages hold
        xl_va    = 32'h8765_4321;
        xl_stall = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_flag("xl_valid", 1'b0, xl_valid);
            @(posedge clk);
            #1;
        end
        xl_stall = 1'b0;
        @(posedge clk);
        #1 xl_stall = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_flag("xl_valid", 1'b1, xl_valid);
            check_pa("xl_pa", a.pa, xl_pa);
            check_flag("xl_tlb_hit", a.tlb_hit, xl_tlb_hit);
            @(posedge clk);
            #1;
        end
        xl_stall = 1'b0;
        @(posedge clk);
        #1;
        @(negedge clk);
        check_flag("xl_valid", 1'b0, xl_valid);

        // Flush with one request in stage 1 and one at the input
        @(posedge clk);
        #1 xl_req = 1'b1;
        xl_va = entry_va(5, 1'b0, 0);
        @(posedge clk);
        #1 flush = 1'b1;
        @(posedge clk);
        #1 flush = 1'b0;
        xl_req = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_flag("xl_valid", 1'b0, xl_valid);
            @(posedge clk);
            #1;
        end
        check_en = 1'b1;

        // Every invalidate op on a fresh set of entries
        for (int op = 0; op < 7; op++) begin
            fill_all();
            r = $random(seed);
            invalidate(op, op == 6 ? csr_asid : m_asid[r[3:0]],
                       entry_va(r[3:0], 1'b0, $random(seed)));
            for (int i = 0; i < `TLB_NUM; i++) begin
                search_check(m_asid[i], entry_va(i, 1'b0, $random(seed)));
            end
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/tlb_entry_pkg.sv
src/tlb_cmd_pkg.sv
src/tlb_entry_array.sv
src/tlb_match.sv
src/tlb_translate_pipe.sv
src/tlb_mgmt.sv
src/tlb_top.sv
test/tb_clock_gen.sv
test/tlb_top_tb.sv
